// File: Makefile
# Verilator build and run of the system trace module testbench

VERILATOR ?= verilator
TOP       ?= stm_tb
FLIST     ?= sw_trace.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: sw_trace.f
verilog/stm_pkg.sv
verilog/stm_event_fifo.sv
verilog/stm_trace_sample.sv
verilog/stm_event_packetizer.sv
verilog/stm_reg_ctrl.sv
verilog/stm_top.sv
verif/stm_tb.sv

// File: verif/stm_tb.sv
/* system trace module testbench
   register requests, random trace traffic with back-pressure,
   packet collector and event model */

`timescale 1ns/1ps

module stm_tb import stm_pkg::*; ();

  localparam int          VAL_WIDTH = 64;
  localparam int          NW        = VAL_WIDTH / 16;
  localparam int          TRACE_LEN = 6 + NW;
  localparam int          OVF_LEN   = 6;
  localparam int          TIMEOUT   = 5000;
  localparam logic [15:0] MY_ID     = 16'h0005;

  logic                 clk;
  logic                 arst_n;
  logic [15:0]          id;
  dii_flit              debug_in;
  logic                 debug_in_ready;
  dii_flit              debug_out;
  logic                 debug_out_ready;
  logic                 trace_valid;
  logic [15:0]          trace_id;
  logic [VAL_WIDTH-1:0] trace_value;

  integer      seed = 94096;
  logic        tracing_on = 1'b0;
  logic        bp_en = 1'b0;
  logic [15:0] dest_exp = 16'h0;
  // collector state
  logic [15:0] pkt_w [16];
  int          pkt_len = 0;
  dii_flit     prev_flit;
  logic        prev_hold = 1'b0;
  // responses {len, dest, src, header, data}, model entries {id, value}
  logic [79:0] resp_q [$];
  logic [79:0] model_q [$];
  int          sent = 0;
  int          delivered = 0;
  int          ovf_sum = 0;
  int          pkt_count = 0;
  logic [31:0] last_ts = '0;
  logic        ts_seen = 1'b0;
  logic [15:0] req_w [5];
  logic [15:0] reg_addr [6];
  logic [15:0] reg_exp [6];

  stm_top UUT (
    .clk             (clk),
    .arst_n          (arst_n),
    .id              (id),
    .debug_in        (debug_in),
    .debug_in_ready  (debug_in_ready),
    .debug_out       (debug_out),
    .debug_out_ready (debug_out_ready),
    .trace_valid     (trace_valid),
    .trace_id        (trace_id),
    .trace_value     (trace_value)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // random output stall, 1 in 4 cycles low when enabled
  initial begin
    debug_out_ready = 1'b1;
    forever begin
      @(posedge clk);
      if (bp_en) begin
        debug_out_ready <= (($random(seed) & 3) != 0);
      end else begin
        debug_out_ready <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // checks and failure
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [79:0] exp,
                             input logic [79:0] act);
    if (exp !== act) begin
      $display("FAILED %s expected %0h actual %0h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR %s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  // ----------------------------------------------------------------------
  // packet collector and event model
  // ----------------------------------------------------------------------
  task automatic take_packet(input int n);
    stm_hdr_u             h;
    logic [31:0]          ts;
    logic [VAL_WIDTH-1:0] val;
    logic [79:0]          got;
    logic                 found;
    if (n < 3) abort_run("packet shorter than its header");
    h.raw = pkt_w[2];
    pkt_count++;
    if (h.hdr.ptype == STM_TYPE_REG) begin
      resp_q.push_back({16'(n), pkt_w[0], pkt_w[1], pkt_w[2], (n > 3) ? pkt_w[3] : 16'h0});
    end else if (h.hdr.ptype == STM_TYPE_EVENT) begin
      check_value("event destination", dest_exp, pkt_w[0]);
      check_value("event source", MY_ID, pkt_w[1]);
      ts = {pkt_w[4], pkt_w[3]};
      if (ts_seen && ts <= last_ts) abort_run("event timestamps not strictly increasing");
      last_ts = ts;
      ts_seen = 1'b1;
      if (h.hdr.subtype == STM_EV_OVERFLOW) begin
        check_value("overflow length", OVF_LEN, n);
        ovf_sum += pkt_w[5];
      end else if (h.hdr.subtype == STM_EV_TRACE) begin
        check_value("trace length", TRACE_LEN, n);
        // value words least significant first
        for (int i = 0; i < NW; i++) begin
          val[16*i +: 16] = pkt_w[6+i];
        end
        got = {pkt_w[5], val};
        if (model_q.size() == 0) abort_run("trace event with no event sent");
        if (!bp_en) begin
          check_value("trace event", model_q.pop_front(), got);
        end else begin
          // lost events are skipped, order must hold
          found = 1'b0;
          while (!found && model_q.size() > 0) begin
            if (model_q.pop_front() == got) found = 1'b1;
          end
          if (!found) abort_run("trace event out of order or never sent");
        end
        delivered++;
      end else begin
        abort_run("unknown event subtype");
      end
    end else begin
      abort_run("unknown packet type on debug_out");
    end
  endtask

  // sampled at negedge, transfer happens at the following posedge
  always @(negedge clk) begin
    if (arst_n) begin
      if (prev_hold && pkt_len > 0 && debug_out !== prev_flit) begin
        abort_run("flit changed while stalled inside a packet");
      end
      prev_hold = debug_out.valid && !debug_out_ready;
      prev_flit = debug_out;
      if (debug_out.valid && debug_out_ready) begin
        if (pkt_len == 16) abort_run("packet longer than 16 flits");
        pkt_w[pkt_len] = debug_out.data;
        if (debug_out.last) begin
          take_packet(pkt_len + 1);
          pkt_len = 0;
        end else begin
          pkt_len = pkt_len + 1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // request driver
  // ----------------------------------------------------------------------
  task automatic send_request(input int n);
    int t;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      debug_in <= '{1'b1, i == n - 1, req_w[i]};
      t = 0;
      do begin
        @(negedge clk);
        t++;
        if (t > TIMEOUT) abort_run("debug_in_ready stayed low");
      end while (!debug_in_ready);
    end
    @(posedge clk);
    debug_in <= '0;
  endtask

  task automatic await_response(output logic [79:0] r);
    int t = 0;
    while (resp_q.size() == 0) begin
      @(posedge clk);
      t++;
      if (t > TIMEOUT) abort_run("no register response arrived");
    end
    r = resp_q.pop_front();
  endtask

  task automatic reg_access(input logic write, input logic [15:0] addr,
                            input logic [15:0] wdata, input logic exp_err,
                            input logic [15:0] exp_data, input string name);
    logic [15:0] src;
    logic [15:0] exp_len;
    logic [79:0] r;
    stm_hdr_u    h;
    src             = 16'($random(seed));
    h.raw           = '0;
    h.hdr.ptype     = STM_TYPE_REG;
    h.hdr.subtype   = write ? STM_REQ_WRITE_16 : STM_REQ_READ_16;
    req_w[0]        = MY_ID;
    req_w[1]        = src;
    req_w[2]        = h.raw;
    req_w[3]        = addr;
    req_w[4]        = wdata;
    send_request(write ? 5 : 4);
    // input closed while the response is pending
    @(negedge clk);
    check_value("ready while response pending", 1'b0, debug_in_ready);
    await_response(r);
    // back to the requester, data only on a good read
    h.hdr.subtype = exp_err ? STM_RESP_ERR : STM_RESP_OK_16;
    exp_len       = (exp_err || write) ? 16'd3 : 16'd4;
    check_value(name, {exp_len, src, MY_ID, h.raw, (exp_len == 16'd4) ? exp_data : 16'h0}, r);
  endtask

  // ----------------------------------------------------------------------
  // trace stimulus
  // ----------------------------------------------------------------------
  task automatic drive_events(input int n, input int min_gap, input int span);
    int                   gap;
    logic [15:0]          id_r;
    logic [VAL_WIDTH-1:0] val_r;
    for (int i = 0; i < n; i++) begin
      gap = min_gap + (($random(seed) & 32'h7fff_ffff) % span);
      repeat (gap) begin
        @(posedge clk);
        trace_valid <= 1'b0;
      end
      id_r  = 16'($random(seed));
      val_r = {$random(seed), $random(seed)};
      @(posedge clk);
      trace_valid <= 1'b1;
      trace_id    <= id_r;
      trace_value <= val_r;
      if (tracing_on) begin
        model_q.push_back({id_r, val_r});
        sent++;
      end
    end
    @(posedge clk);
    trace_valid <= 1'b0;
  endtask

  task automatic wait_drained();
    int t = 0;
    while (delivered + ovf_sum < sent) begin
      @(posedge clk);
      t++;
      if (t > 4 * TIMEOUT) abort_run("events neither delivered nor counted as lost");
    end
    repeat (50) @(posedge clk);
    check_value("events accounted", sent, delivered + ovf_sum);
  endtask

  task automatic clear_tally();
    sent      = 0;
    delivered = 0;
    ovf_sum   = 0;
    model_q.delete();
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    int          n0;
    int          k;
    logic [15:0] addr;
    arst_n      = 1'b0;
    id          = MY_ID;
    debug_in    = '0;
    trace_valid = 1'b0;
    trace_id    = '0;
    trace_value = '0;
    reg_addr = '{STM_ADDR_VENDOR, STM_ADDR_TYPE, STM_ADDR_VERSION,
                 STM_ADDR_VALWIDTH, STM_ADDR_CS, STM_ADDR_EVDEST};
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);

    // identity and reset values
    reg_access(1'b0, STM_ADDR_VENDOR, 16'h0, 1'b0, 16'h1, "read vendor");
    reg_access(1'b0, STM_ADDR_TYPE, 16'h0, 1'b0, 16'h4, "read type");
    reg_access(1'b0, STM_ADDR_VERSION, 16'h0, 1'b0, 16'h0, "read version");
    reg_access(1'b0, STM_ADDR_VALWIDTH, 16'h0, 1'b0, 16'(VAL_WIDTH), "read value width");
    reg_access(1'b0, STM_ADDR_CS, 16'h0, 1'b0, 16'h0, "read control after reset");
    reg_access(1'b0, STM_ADDR_EVDEST, 16'h0, 1'b0, 16'h0, "read evdest after reset");

    // unmapped reads and read-only writes
    for (int i = 0; i < 6; i++) begin
      addr = 16'($random(seed));
      if (addr < 16'h5 || addr == STM_ADDR_VALWIDTH) addr = addr + 16'h5;
      reg_access(1'b0, addr, 16'h0, 1'b1, 16'h0, "read unmapped");
    end
    reg_access(1'b1, STM_ADDR_VENDOR, 16'($random(seed)), 1'b1, 16'h0, "write vendor");
    reg_access(1'b1, STM_ADDR_VALWIDTH, 16'($random(seed)), 1'b1, 16'h0, "write value width");

    // tracing still off
    n0 = pkt_count;
    drive_events(20, 0, 4);
    repeat (200) @(posedge clk);
    check_value("packets while tracing off", n0, pkt_count);

    // enable, spaced events, exact order
    dest_exp = 16'($random(seed));
    reg_access(1'b1, STM_ADDR_EVDEST, dest_exp, 1'b0, 16'h0, "write evdest");
    reg_access(1'b0, STM_ADDR_EVDEST, 16'h0, 1'b0, dest_exp, "read evdest");
    reg_access(1'b1, STM_ADDR_CS, 16'h1, 1'b0, 16'h0, "enable tracing");
    tracing_on = 1'b1;
    reg_exp = '{16'h1, 16'h4, 16'h0, 16'(VAL_WIDTH), 16'h1, dest_exp};
    clear_tally();
    drive_events(24, 14, 8);
    wait_drained();
    check_value("overflow without stall", 0, ovf_sum);

    // dense bursts under stall, register reads in between
    clear_tally();
    bp_en = 1'b1;
    fork
      drive_events(80, 0, 2);
      begin
        for (int i = 0; i < 10; i++) begin
          k = ($random(seed) & 32'h7fff_ffff) % 6;
          repeat (k + 3) @(posedge clk);
          reg_access(1'b0, reg_addr[k], 16'h0, 1'b0, reg_exp[k], "read during traffic");
        end
      end
    join
    wait_drained();
    bp_en = 1'b0;
    check_value("overflow seen", 1, ovf_sum > 0);

    $display("TEST OK");
    $finish;
  end

endmodule

// File: verilog/stm_event_fifo.sv
/* event FIFO
   circular buffer of trace entries, valid/ready on both sides */

`timescale 1ns/1ps

module stm_event_fifo import stm_pkg::*; #(
  parameter int VAL_WIDTH  = 64,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  stm_evt_desc_t        in_desc,
  input  logic [VAL_WIDTH-1:0] in_value,
  input  logic                 in_valid,
  output logic                 in_ready,
  output stm_evt_desc_t        out_desc,
  output logic [VAL_WIDTH-1:0] out_value,
  output logic                 out_valid,
  input  logic                 out_ready
);

  // pointers wrap on their own, depth is a power of two
  localparam int AW = $clog2(FIFO_DEPTH);

  stm_evt_desc_t        desc_mem [FIFO_DEPTH];
  logic [VAL_WIDTH-1:0] val_mem  [FIFO_DEPTH];
  logic [AW-1:0]        wr_ptr;
  logic [AW-1:0]        rd_ptr;
  logic [AW:0]          count;
  logic                 wr_en;
  logic                 rd_en;

  assign in_ready  = count != (AW+1)'(FIFO_DEPTH);
  assign out_valid = count != '0;
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;
  assign out_desc  = desc_mem[rd_ptr];
  assign out_value = val_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      desc_mem[wr_ptr] <= in_desc;
      val_mem[wr_ptr]  <= in_value;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      // simultaneous push and pop leaves the count alone
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  a_count_max : assert property (@(posedge clk) disable iff (!arst_n)
    count <= (AW+1)'(FIFO_DEPTH));

endmodule

// File: verilog/stm_event_packetizer.sv
/* event packetizer
   walks one FIFO entry out as a trace or overflow packet of 16-bit flits */

`timescale 1ns/1ps

module stm_event_packetizer import stm_pkg::*; #(
  parameter int VAL_WIDTH = 64
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [15:0]          id,
  input  logic [15:0]          evt_dest,
  input  stm_evt_desc_t        in_desc,
  input  logic [VAL_WIDTH-1:0] in_value,
  input  logic                 in_valid,
  output logic                 in_ready,
  output dii_flit              event_flit,
  input  logic                 event_flit_ready
);

  // dest, src, header, ts low, ts high, id or count, then value words
  localparam int NW        = VAL_WIDTH / 16;
  localparam int TRACE_LEN = 6 + NW;
  localparam int OVF_LEN   = 6;

  logic [3:0] cnt;
  logic       last_flit;
  logic       fire;
  stm_hdr_u   hdr;

  always_comb begin
    hdr.raw         = '0;
    hdr.hdr.ptype   = STM_TYPE_EVENT;
    hdr.hdr.subtype = in_desc.overflow ? STM_EV_OVERFLOW : STM_EV_TRACE;
  end

  assign last_flit = in_desc.overflow ? (cnt == 4'(OVF_LEN - 1))
                                      : (cnt == 4'(TRACE_LEN - 1));

  always_comb begin
    event_flit.valid = in_valid;
    event_flit.last  = last_flit;
    case (cnt)
      4'd0:    event_flit.data = evt_dest;
      4'd1:    event_flit.data = id;
      4'd2:    event_flit.data = hdr.raw;
      4'd3:    event_flit.data = in_desc.timestamp[15:0];
      4'd4:    event_flit.data = in_desc.timestamp[31:16];
      // lost count sits in the id field of an overflow entry
      4'd5:    event_flit.data = in_desc.trace_id;
      // value words, least significant first
      default: event_flit.data = 16'(in_value >> (16 * (cnt - 4'd6)));
    endcase
  end

  assign fire     = in_valid && event_flit_ready;
  // entry popped as its last flit goes out
  assign in_ready = fire && last_flit;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (fire) begin
      cnt <= last_flit ? 4'd0 : cnt + 4'd1;
    end
  end

  a_flit_stable : assert property (@(posedge clk) disable iff (!arst_n)
    event_flit.valid && !event_flit_ready |=> $stable(event_flit));

endmodule

// File: verilog/stm_pkg.sv
/* system trace module shared types
   debug flit, packet header views, event entry and protocol constants */

package stm_pkg;

  // one debug network word
  typedef struct packed {
    logic        valid;
    logic        last;
    logic [15:0] data;
  } dii_flit;

  // decoded view of flit 2 of every packet
  typedef struct packed {
    logic [1:0] ptype;
    logic [3:0] subtype;
    logic [9:0] rsvd;
  } stm_hdr_s;

  // same word, raw or decoded
  typedef union packed {
    logic [15:0] raw;
    stm_hdr_s    hdr;
  } stm_hdr_u;

  // fixed part of a FIFO entry, value travels beside it
  typedef struct packed {
    logic        overflow;
    logic [31:0] timestamp;
    logic [15:0] trace_id;
  } stm_evt_desc_t;

  // ----------------------------------------------------------------------
  // packet types and subtypes
  // ----------------------------------------------------------------------
  localparam logic [1:0] STM_TYPE_REG   = 2'b00;
  localparam logic [1:0] STM_TYPE_EVENT = 2'b10;

  localparam logic [3:0] STM_REQ_READ_16  = 4'b0000;
  localparam logic [3:0] STM_REQ_WRITE_16 = 4'b0100;
  localparam logic [3:0] STM_RESP_OK_16   = 4'b1000;
  localparam logic [3:0] STM_RESP_ERR     = 4'b1100;

  localparam logic [3:0] STM_EV_TRACE    = 4'b0000;
  localparam logic [3:0] STM_EV_OVERFLOW = 4'b0101;

  // ----------------------------------------------------------------------
  // register map
  // ----------------------------------------------------------------------
  localparam logic [15:0] STM_ADDR_VENDOR   = 16'h0000;
  localparam logic [15:0] STM_ADDR_TYPE     = 16'h0001;
  localparam logic [15:0] STM_ADDR_VERSION  = 16'h0002;
  localparam logic [15:0] STM_ADDR_CS       = 16'h0003;
  localparam logic [15:0] STM_ADDR_EVDEST   = 16'h0004;
  localparam logic [15:0] STM_ADDR_VALWIDTH = 16'h0200;

endpackage

// File: verilog/stm_reg_ctrl.sv
/* register access controller
   decodes register requests, holds control registers, sends responses
   and merges them with event packets on the output port */

`timescale 1ns/1ps

module stm_reg_ctrl import stm_pkg::*; #(
  parameter int          VAL_WIDTH   = 64,
  parameter logic [15:0] MOD_VENDOR  = 16'h1,
  parameter logic [15:0] MOD_TYPE    = 16'h4,
  parameter logic [15:0] MOD_VERSION = 16'h0
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [15:0] id,
  input  dii_flit     debug_in,
  output logic        debug_in_ready,
  output dii_flit     debug_out,
  input  logic        debug_out_ready,
  input  dii_flit     event_flit,
  output logic        event_flit_ready,
  output logic        trace_en,
  output logic [15:0] evt_dest
);

  logic [2:0]  rx_cnt;
  logic [15:0] src_q;
  stm_hdr_u    hdr_q;
  logic [15:0] addr_q;
  logic [15:0] wdata_q;
  logic        exec;
  logic        resp_pending;
  logic [1:0]  tx_cnt;
  logic        open_q;
  logic        sel_q;
  logic        sel;
  logic        rx_fire;
  logic        is_req;
  logic        is_write;
  logic        err;
  logic [15:0] rdata;
  stm_hdr_u    rhdr;
  dii_flit     resp_flit;
  logic        resp_last;
  logic        resp_fire;
  logic        out_fire;
  logic        evt_fire;
  logic        evt_open;

  // ----------------------------------------------------------------------
  // receive side
  // ----------------------------------------------------------------------
  // blocked until the pending response is out
  assign debug_in_ready = !resp_pending;
  assign rx_fire        = debug_in.valid && debug_in_ready;
  assign is_write       = hdr_q.hdr.subtype == STM_REQ_WRITE_16;

  // read ends at flit 3, write at flit 4, anything else gets dropped
  assign is_req = hdr_q.hdr.ptype == STM_TYPE_REG &&
                  ((hdr_q.hdr.subtype == STM_REQ_READ_16 && rx_cnt == 3'd3) ||
                   (is_write && rx_cnt == 3'd4));

  always_ff @(posedge clk) begin
    if (rx_fire) begin
      case (rx_cnt)
        3'd1:    src_q   <= debug_in.data;
        3'd2:    hdr_q   <= debug_in.data;
        3'd3:    addr_q  <= debug_in.data;
        3'd4:    wdata_q <= debug_in.data;
        default: ;
      endcase
    end
  end

  // register decode, addr_q is stable from exec until the response ends
  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (addr_q)
      STM_ADDR_VENDOR:   rdata = MOD_VENDOR;
      STM_ADDR_TYPE:     rdata = MOD_TYPE;
      STM_ADDR_VERSION:  rdata = MOD_VERSION;
      STM_ADDR_CS:       rdata = {15'b0, trace_en};
      STM_ADDR_EVDEST:   rdata = evt_dest;
      STM_ADDR_VALWIDTH: rdata = 16'(VAL_WIDTH);
      default:           err   = 1'b1;
    endcase
    // only control and event destination are writable
    if (is_write && addr_q != STM_ADDR_CS && addr_q != STM_ADDR_EVDEST) begin
      err = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_cnt       <= '0;
      exec         <= 1'b0;
      resp_pending <= 1'b0;
      trace_en     <= 1'b0;
      evt_dest     <= '0;
    end else begin
      exec <= 1'b0;
      if (rx_fire) begin
        if (debug_in.last) begin
          rx_cnt <= '0;
          exec         <= is_req;
          resp_pending <= is_req;
        end else if (rx_cnt != 3'd7) begin
          rx_cnt <= rx_cnt + 3'd1;
        end
      end
      // register writes take effect the cycle after the last flit
      if (exec && is_write && !err) begin
        if (addr_q == STM_ADDR_CS) begin
          trace_en <= wdata_q[0];
        end else begin
          evt_dest <= wdata_q;
        end
      end
      if (resp_fire && resp_last) begin
        resp_pending <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // transmit side
  // ----------------------------------------------------------------------
  always_comb begin
    rhdr.raw         = '0;
    rhdr.hdr.ptype   = STM_TYPE_REG;
    rhdr.hdr.subtype = err ? STM_RESP_ERR : STM_RESP_OK_16;
  end

  // read ok carries one data word, the rest end at the header
  assign resp_last = tx_cnt == ((err || is_write) ? 2'd2 : 2'd3);

  always_comb begin
    resp_flit.valid = resp_pending && !exec;
    resp_flit.last  = resp_last;
    case (tx_cnt)
      2'd0:    resp_flit.data = src_q;
      2'd1:    resp_flit.data = id;
      2'd2:    resp_flit.data = rhdr.raw;
      default: resp_flit.data = rdata;
    endcase
  end

  // grant held per packet, responses win when the port is free
  assign sel              = open_q ? sel_q : resp_flit.valid;
  assign debug_out        = sel ? resp_flit : event_flit;
  assign event_flit_ready = !sel && debug_out_ready;
  assign resp_fire        = sel && resp_flit.valid && debug_out_ready;
  assign out_fire         = debug_out.valid && debug_out_ready;
  assign evt_fire         = event_flit.valid && event_flit_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_cnt <= '0;
      open_q <= 1'b0;
      sel_q  <= 1'b0;
    end else begin
      if (resp_fire) begin
        tx_cnt <= resp_last ? 2'd0 : tx_cnt + 2'd1;
      end
      if (out_fire) begin
        open_q <= !debug_out.last;
        sel_q  <= sel;
      end
    end
  end

  // event packet open on the port, seen from the event flits alone
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      evt_open <= 1'b0;
    end else if (evt_fire) begin
      evt_open <= !event_flit.last;
    end
  end

  // no response flit inside an event packet, nor the other way round
  a_grant_held : assert property (@(posedge clk) disable iff (!arst_n)
    !(resp_fire && evt_open) && !(evt_fire && tx_cnt != 2'd0));

endmodule

// File: verilog/stm_top.sv
/* system trace module top level
   register controller, trace sampler, event FIFO and packetizer */

`timescale 1ns/1ps

module stm_top import stm_pkg::*; #(
  parameter int          VAL_WIDTH   = 64,
  parameter int          FIFO_DEPTH  = 8,
  parameter logic [15:0] MOD_VENDOR  = 16'h1,
  parameter logic [15:0] MOD_TYPE    = 16'h4,
  parameter logic [15:0] MOD_VERSION = 16'h0
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [15:0]          id,
  input  dii_flit              debug_in,
  output logic                 debug_in_ready,
  output dii_flit              debug_out,
  input  logic                 debug_out_ready,
  input  logic                 trace_valid,
  input  logic [15:0]          trace_id,
  input  logic [VAL_WIDTH-1:0] trace_value
);

  // sampler to FIFO
  stm_evt_desc_t        smp_desc;
  logic [VAL_WIDTH-1:0] smp_value;
  logic                 smp_valid;
  logic                 smp_ready;

  // FIFO to packetizer
  stm_evt_desc_t        pkt_desc;
  logic [VAL_WIDTH-1:0] pkt_value;
  logic                 pkt_valid;
  logic                 pkt_ready;

  // packetizer to controller, and control back
  dii_flit              event_flit;
  logic                 event_flit_ready;
  logic                 trace_en;
  logic [15:0]          evt_dest;

  stm_reg_ctrl #(
    .VAL_WIDTH   (VAL_WIDTH),
    .MOD_VENDOR  (MOD_VENDOR),
    .MOD_TYPE    (MOD_TYPE),
    .MOD_VERSION (MOD_VERSION)
  ) u_reg_ctrl (
    .clk              (clk),
    .arst_n           (arst_n),
    .id               (id),
    .debug_in         (debug_in),
    .debug_in_ready   (debug_in_ready),
    .debug_out        (debug_out),
    .debug_out_ready  (debug_out_ready),
    .event_flit       (event_flit),
    .event_flit_ready (event_flit_ready),
    .trace_en         (trace_en),
    .evt_dest         (evt_dest)
  );

  stm_trace_sample #(
    .VAL_WIDTH (VAL_WIDTH)
  ) u_sample (
    .clk         (clk),
    .arst_n      (arst_n),
    .trace_en    (trace_en),
    .trace_valid (trace_valid),
    .trace_id    (trace_id),
    .trace_value (trace_value),
    .out_desc    (smp_desc),
    .out_value   (smp_value),
    .out_valid   (smp_valid),
    .out_ready   (smp_ready)
  );

  stm_event_fifo #(
    .VAL_WIDTH  (VAL_WIDTH),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_desc   (smp_desc),
    .in_value  (smp_value),
    .in_valid  (smp_valid),
    .in_ready  (smp_ready),
    .out_desc  (pkt_desc),
    .out_value (pkt_value),
    .out_valid (pkt_valid),
    .out_ready (pkt_ready)
  );

  stm_event_packetizer #(
    .VAL_WIDTH (VAL_WIDTH)
  ) u_packetizer (
    .clk              (clk),
    .arst_n           (arst_n),
    .id               (id),
    .evt_dest         (evt_dest),
    .in_desc          (pkt_desc),
    .in_value         (pkt_value),
    .in_valid         (pkt_valid),
    .in_ready         (pkt_ready),
    .event_flit       (event_flit),
    .event_flit_ready (event_flit_ready)
  );

endmodule

// File: verilog/stm_trace_sample.sv
/* trace sampler
   timestamps trace strobes, counts events lost to a full FIFO
   and inserts overflow entries */

`timescale 1ns/1ps

module stm_trace_sample import stm_pkg::*; #(
  parameter int VAL_WIDTH = 64
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 trace_en,
  input  logic                 trace_valid,
  input  logic [15:0]          trace_id,
  input  logic [VAL_WIDTH-1:0] trace_value,
  output stm_evt_desc_t        out_desc,
  output logic [VAL_WIDTH-1:0] out_value,
  output logic                 out_valid,
  input  logic                 out_ready
);

  logic [31:0] timestamp;
  logic [15:0] lost_cnt;
  logic        evt_req;
  logic        slot_free;
  logic        lost;

  assign evt_req   = trace_valid && trace_en;
  // output register empty or draining this cycle
  assign slot_free = !out_valid || out_ready;
  assign lost      = lost_cnt != '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      timestamp <= '0;
      lost_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      // free running, wraps
      timestamp <= timestamp + 32'd1;
      if (slot_free) begin
        // overflow first, a strobe in the same cycle starts the next count
        if (lost) begin
          out_valid <= 1'b1;
          lost_cnt  <= 16'(evt_req);
        end else begin
          out_valid <= evt_req;
        end
      end else if (evt_req && lost_cnt != 16'hFFFF) begin
        lost_cnt <= lost_cnt + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (slot_free) begin
      if (lost) begin
        out_desc.overflow  <= 1'b1;
        out_desc.timestamp <= timestamp;
        out_desc.trace_id  <= lost_cnt;
      end else if (evt_req) begin
        out_desc.overflow  <= 1'b0;
        out_desc.timestamp <= timestamp;
        out_desc.trace_id  <= trace_id;
        out_value          <= trace_value;
      end
    end
  end

  a_hold_stable : assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_desc) && $stable(out_value));

endmodule
